// File: rtl/hififo_pkg.sv
// shared sizes, register map, TLP header views and request records used by every hififo block
package hififo_pkg;

   // stream and storage sizing
   localparam int data_w     = 64;
   localparam int fifo_depth = 16;
   localparam int fifo_aw    = 4;
   localparam int dw_addr_w  = 10;
   localparam int timer_w    = 7;

   // dword offsets inside the BAR
   localparam logic [dw_addr_w-1:0] reg_fifo_data  = 10'd0;
   localparam logic [dw_addr_w-1:0] reg_status     = 10'd1;
   localparam logic [dw_addr_w-1:0] reg_irq_thresh = 10'd2;

   // max wait of unread data before an MSI
   localparam logic [timer_w-1:0] irq_holdoff_cycles = 7'd64;

   // fmt/type codes of the TLPs handled here
   localparam logic [6:0] fmt_type_mwr32 = 7'h40;
   localparam logic [6:0] fmt_type_mrd32 = 7'h00;
   localparam logic [6:0] fmt_type_cpld  = 7'h4a;

   // MSI vectors
   localparam logic [3:0] irq_num_thresh  = 4'd0;
   localparam logic [3:0] irq_num_timeout = 4'd1;

   typedef struct packed {
      logic [7:0] bus;
      logic [4:0] dev;
      logic [2:0] func;
   } pci_id_t;

   // dw0 in the low half, dw1 in the high half, as on the 64-bit stream
   typedef struct packed {
      pci_id_t     requester_id;
      logic [7:0]  tag;
      logic [3:0]  last_be;
      logic [3:0]  first_be;
      logic        rsvd;
      logic [6:0]  fmt_type;
      logic [13:0] flags;
      logic [9:0]  length;
   } req_hdr_t;

   typedef struct packed {
      pci_id_t     completer_id;
      logic [2:0]  status;
      logic        bcm;
      logic [11:0] byte_count;
      logic        rsvd;
      logic [6:0]  fmt_type;
      logic [13:0] flags;
      logic [9:0]  length;
   } cpl_hdr_t;

   typedef union packed {
      req_hdr_t req;
      cpl_hdr_t cpl;
   } tlp_qw0_u;

   typedef struct packed {
      pci_id_t              requester_id;
      logic [7:0]           tag;
      logic [dw_addr_w-1:0] dw_addr;
      logic [6:0]           lower_addr;
   } rd_req_t;

   typedef struct packed {
      logic                 strobe;
      logic [dw_addr_w-1:0] dw_addr;
      logic [31:0]          data;
   } wr_req_t;

   typedef enum logic [1:0] {
      LINK_DOWN,
      LINK_ACTIVE,
      TURNOFF_WAIT,
      TURNED_OFF
   } link_state_e;

endpackage

// File: rtl/pcie_link_ctrl.sv
// link state tracking: user-side reset from the core and the PME turn-off handshake
`timescale 1ns/10ps

module pcie_link_ctrl (
   input  logic clock,
   input  logic rst,
   input  logic user_reset,
   input  logic user_lnk_up,
   input  logic cfg_to_turnoff,
   input  logic cpl_pending,
   output logic pci_reset,
   output logic cfg_turnoff_ok
);
   import hififo_pkg::*;

   link_state_e state;
   logic        link_ok;

   assign link_ok = user_lnk_up && !user_reset;

   // user logic stays in reset until the core reports a live link
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         pci_reset <= 1'b1;
      end
      else
      begin
         pci_reset <= user_reset | ~user_lnk_up;
      end
   end

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         state <= LINK_DOWN;
      end
      else if (!link_ok)
      begin
         state <= LINK_DOWN;
      end
      else
      begin
         case (state)
            LINK_DOWN:
               state <= LINK_ACTIVE;
            LINK_ACTIVE:
               if (cfg_to_turnoff)
               begin
                  // ack right away when nothing is in flight
                  state <= cpl_pending ? TURNOFF_WAIT : TURNED_OFF;
               end
            TURNOFF_WAIT:
               if (!cfg_to_turnoff)
                  state <= LINK_ACTIVE;
               else if (!cpl_pending)
                  state <= TURNED_OFF;
            TURNED_OFF:
               if (!cfg_to_turnoff)
                  state <= LINK_ACTIVE;
            default:
               state <= LINK_DOWN;
         endcase
      end
   end

   // held for as long as the core keeps the request up
   assign cfg_turnoff_ok = (state == TURNED_OFF);

endmodule

// File: rtl/tlp_rx_decoder.sv
// receive-stream parser turning single-dword memory requests into write strobes and read requests
`timescale 1ns/10ps

module tlp_rx_decoder (
   input  logic                          clock,
   input  logic                          rst,
   input  logic                          rx_tvalid,
   input  logic                          rx_tlast,
   input  logic [hififo_pkg::data_w-1:0] rx_tdata,
   output hififo_pkg::wr_req_t           wr,
   output hififo_pkg::rd_req_t           rd,
   output logic                          rd_strobe
);
   import hififo_pkg::*;

   // 0 = header beat, 1 = address beat, 2 = anything beyond
   logic [1:0] beat;
   tlp_qw0_u   qw0;
   logic       addr_beat;
   logic       req_done;
   logic       is_wr;
   logic       is_rd;

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         beat <= 2'd0;
      end
      else if (rx_tvalid)
      begin
         if (rx_tlast)
            beat <= 2'd0;
         else if (beat != 2'd2)
            beat <= beat + 2'd1;
      end
   end

   always_ff @(posedge clock)
   begin
      if (rx_tvalid && (beat == 2'd0))
      begin
         qw0 <= rx_tdata;
      end
   end

   assign addr_beat = rx_tvalid && (beat == 2'd1);

   // only a two-beat packet asking for exactly one dword
   assign req_done = addr_beat && rx_tlast && (qw0.req.length == 10'd1);
   assign is_wr    = req_done && (qw0.req.fmt_type == fmt_type_mwr32);
   assign is_rd    = req_done && (qw0.req.fmt_type == fmt_type_mrd32);

   always_ff @(posedge clock)
   begin
      if (addr_beat)
      begin
         wr.dw_addr      <= rx_tdata[dw_addr_w+1:2];
         wr.data         <= rx_tdata[63:32];
         rd.requester_id <= qw0.req.requester_id;
         rd.tag          <= qw0.req.tag;
         rd.dw_addr      <= rx_tdata[dw_addr_w+1:2];
         rd.lower_addr   <= {rx_tdata[6:2], 2'b00};
      end
      if (rst)
      begin
         wr.strobe <= 1'b0;
         rd_strobe <= 1'b0;
      end
      else
      begin
         wr.strobe <= is_wr;
         rd_strobe <= is_rd;
      end
   end

endmodule

// File: rtl/h2c_fifo.sv
// host-to-card word FIFO, first-word-fall-through read side with a fill level
`timescale 1ns/10ps

module h2c_fifo (
   input  logic                           clock,
   input  logic                           rst,
   input  logic                           push,
   input  logic [31:0]                    push_data,
   input  logic                           fifo_rd,
   output logic [31:0]                    fifo_dout,
   output logic                           fifo_empty,
   output logic [hififo_pkg::fifo_aw:0]   fifo_level
);
   import hififo_pkg::*;

   logic [31:0]        mem [fifo_depth];
   logic [fifo_aw-1:0] wr_ptr;
   logic [fifo_aw-1:0] rd_ptr;
   logic               do_push;
   logic               do_pop;

   // writes into a full buffer are lost
   assign do_push = push && (fifo_level != (fifo_aw+1)'(fifo_depth));
   assign do_pop  = fifo_rd && !fifo_empty;

   always_ff @(posedge clock)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_level <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop)
            fifo_level <= fifo_level + 1'b1;
         else if (do_pop && !do_push)
            fifo_level <= fifo_level - 1'b1;
      end
   end

   assign fifo_dout  = mem[rd_ptr];
   assign fifo_empty = (fifo_level == '0);

endmodule

// File: rtl/irq_holdoff_timer.sv
// MSI request generation from the FIFO level threshold and a holdoff timer on waiting data
`timescale 1ns/10ps

module irq_holdoff_timer (
   input  logic                          clock,
   input  logic                          rst,
   input  hififo_pkg::wr_req_t           wr,
   input  logic [hififo_pkg::fifo_aw:0]  fifo_level,
   input  logic                          interrupt_rdy,
   output logic                          interrupt,
   output logic [3:0]                    interrupt_num,
   output logic [hififo_pkg::fifo_aw:0]  irq_thresh
);
   import hififo_pkg::*;

   logic               armed;
   logic [timer_w-1:0] holdoff_cnt;
   logic               fifo_push;
   logic               thresh_hit;
   logic               timed_out;
   logic               fire;

   assign fifo_push  = wr.strobe && (wr.dw_addr == reg_fifo_data);
   assign thresh_hit = (fifo_level != '0) && (fifo_level >= irq_thresh);
   assign timed_out  = (holdoff_cnt == irq_holdoff_cycles);
   assign fire       = armed && (thresh_hit || timed_out);

   always_ff @(posedge clock)
   begin
      if (rst)
         irq_thresh <= (fifo_aw+1)'(fifo_depth);
      else if (wr.strobe && (wr.dw_addr == reg_irq_thresh))
         irq_thresh <= wr.data[fifo_aw:0];
   end

   // counts only while data sits unread and an interrupt may still go out
   always_ff @(posedge clock)
   begin
      if (rst || !armed || (fifo_level == '0))
         holdoff_cnt <= '0;
      else if (!timed_out)
         holdoff_cnt <= holdoff_cnt + 1'b1;
   end

   always_ff @(posedge clock)
   begin
      if (fire)
      begin
         // threshold wins over the timeout
         interrupt_num <= thresh_hit ? irq_num_thresh : irq_num_timeout;
      end
      if (rst)
      begin
         armed     <= 1'b1;
         interrupt <= 1'b0;
      end
      else if (fire)
      begin
         armed     <= 1'b0;
         interrupt <= 1'b1;
      end
      else if (interrupt && interrupt_rdy)
      begin
         interrupt <= 1'b0;
      end
      else if (!armed && !interrupt && fifo_push)
      begin
         armed <= 1'b1;
      end
   end

endmodule

// File: rtl/cpl_tx_builder.sv
// completion TLP generator for register reads, two beats per completion under tx back-pressure
`timescale 1ns/10ps

module cpl_tx_builder (
   input  logic                          clock,
   input  logic                          rst,
   input  logic                          rd_strobe,
   input  logic                          tx_tready,
   input  hififo_pkg::rd_req_t           rd,
   input  hififo_pkg::pci_id_t           pci_id,
   input  logic [hififo_pkg::fifo_aw:0]  fifo_level,
   input  logic [hififo_pkg::fifo_aw:0]  irq_thresh,
   output logic                          tx_tvalid,
   output logic                          tx_tlast,
   output logic                          cpl_pending,
   output logic [hififo_pkg::data_w-1:0] tx_tdata
);
   import hififo_pkg::*;

   rd_req_t     cur_req;
   rd_req_t     q_req;
   rd_req_t     load_req;
   logic [31:0] cur_data;
   logic [31:0] rd_data;
   logic        q_valid;
   logic        beat_acc;
   logic        last_acc;
   logic        load_new;
   logic        load_q;
   logic        store_q;
   tlp_qw0_u    hdr;

   assign beat_acc = tx_tvalid && tx_tready;
   assign last_acc = beat_acc && tx_tlast;

   // straight to the output when it is free, else one slot of queue
   assign load_new = rd_strobe && (!tx_tvalid || (last_acc && !q_valid));
   assign load_q   = q_valid && last_acc;
   assign store_q  = rd_strobe && !load_new && (!q_valid || load_q);
   assign load_req = load_q ? q_req : rd;

   always_comb
   begin
      case (load_req.dw_addr)
         reg_status:     rd_data = 32'(fifo_level);
         reg_irq_thresh: rd_data = 32'(irq_thresh);
         default:        rd_data = '0;
      endcase
   end

   always_ff @(posedge clock)
   begin
      // data sampled once so the beat stays put while stalled
      if (load_new || load_q)
      begin
         cur_req  <= load_req;
         cur_data <= rd_data;
      end
      if (store_q)
         q_req <= rd;
      if (rst)
      begin
         tx_tvalid <= 1'b0;
         tx_tlast  <= 1'b0;
         q_valid   <= 1'b0;
      end
      else
      begin
         if (load_new || load_q)
         begin
            tx_tvalid <= 1'b1;
            tx_tlast  <= 1'b0;
         end
         else if (last_acc)
         begin
            tx_tvalid <= 1'b0;
            tx_tlast  <= 1'b0;
         end
         else if (beat_acc)
         begin
            tx_tlast <= 1'b1;
         end
         if (store_q)
            q_valid <= 1'b1;
         else if (load_q)
            q_valid <= 1'b0;
      end
   end

   always_comb
   begin
      hdr                   = '0;
      hdr.cpl.fmt_type      = fmt_type_cpld;
      hdr.cpl.length        = 10'd1;
      hdr.cpl.completer_id  = pci_id;
      // successful completion
      hdr.cpl.status        = 3'b000;
      hdr.cpl.byte_count    = 12'd4;
   end

   assign tx_tdata = tx_tlast ?
                     {cur_data, cur_req.requester_id, cur_req.tag, 1'b0, cur_req.lower_addr} :
                     hdr;

   // drops on the cycle the final beat is taken
   assign cpl_pending = rd_strobe || q_valid || (tx_tvalid && !last_acc);

endmodule

// File: rtl/hififo_top.sv
// top level of the user-side logic, wired to the user interface of the PCIe endpoint core
`timescale 1ns/10ps

module hififo_top (
   input  logic                          clock,
   input  logic                          rst,
   // core status and power management
   input  logic                          user_reset,
   input  logic                          user_lnk_up,
   input  logic                          cfg_to_turnoff,
   output logic                          cfg_turnoff_ok,
   output logic                          pci_reset,
   input  hififo_pkg::pci_id_t           pci_id,
   // receive stream from the core
   input  logic                          rx_tvalid,
   input  logic                          rx_tlast,
   input  logic [hififo_pkg::data_w-1:0] rx_tdata,
   // transmit stream to the core
   output logic                          tx_tvalid,
   input  logic                          tx_tready,
   output logic                          tx_tlast,
   output logic [hififo_pkg::data_w-1:0] tx_tdata,
   // MSI
   output logic                          interrupt,
   input  logic                          interrupt_rdy,
   output logic [3:0]                    interrupt_num,
   // card-side FIFO read port
   input  logic                          fifo_rd,
   output logic [31:0]                   fifo_dout,
   output logic                          fifo_empty
);
   import hififo_pkg::*;

   logic             blk_rst;
   wr_req_t          wr;
   rd_req_t          rd;
   logic             rd_strobe;
   logic             fifo_push;
   logic [fifo_aw:0] fifo_level;
   logic [fifo_aw:0] irq_thresh;
   logic             cpl_pending;

   // link loss resets everything but the link tracker
   assign blk_rst   = rst | pci_reset;
   assign fifo_push = wr.strobe && (wr.dw_addr == reg_fifo_data);

   pcie_link_ctrl i_pcie_link_ctrl (
      .clock          (clock),
      .rst            (rst),
      .user_reset     (user_reset),
      .user_lnk_up    (user_lnk_up),
      .cfg_to_turnoff (cfg_to_turnoff),
      .cpl_pending    (cpl_pending),
      .pci_reset      (pci_reset),
      .cfg_turnoff_ok (cfg_turnoff_ok)
   );

   tlp_rx_decoder i_tlp_rx_decoder (
      .clock     (clock),
      .rst       (blk_rst),
      .rx_tvalid (rx_tvalid),
      .rx_tlast  (rx_tlast),
      .rx_tdata  (rx_tdata),
      .wr        (wr),
      .rd        (rd),
      .rd_strobe (rd_strobe)
   );

   h2c_fifo i_h2c_fifo (
      .clock      (clock),
      .rst        (blk_rst),
      .push       (fifo_push),
      .push_data  (wr.data),
      .fifo_rd    (fifo_rd),
      .fifo_dout  (fifo_dout),
      .fifo_empty (fifo_empty),
      .fifo_level (fifo_level)
   );

   irq_holdoff_timer i_irq_holdoff_timer (
      .clock         (clock),
      .rst           (blk_rst),
      .wr            (wr),
      .fifo_level    (fifo_level),
      .interrupt_rdy (interrupt_rdy),
      .interrupt     (interrupt),
      .interrupt_num (interrupt_num),
      .irq_thresh    (irq_thresh)
   );

   cpl_tx_builder i_cpl_tx_builder (
      .clock       (clock),
      .rst         (blk_rst),
      .rd_strobe   (rd_strobe),
      .tx_tready   (tx_tready),
      .rd          (rd),
      .pci_id      (pci_id),
      .fifo_level  (fifo_level),
      .irq_thresh  (irq_thresh),
      .tx_tvalid   (tx_tvalid),
      .tx_tlast    (tx_tlast),
      .cpl_pending (cpl_pending),
      .tx_tdata    (tx_tdata)
   );

endmodule

// File: tb/hififo_tb_tasks.svh
// tasks included by the hififo testbench: TLP stimulus, completion capture, FIFO pops and checks

task automatic start_test(input string name);
   cur_test        = name;
   errors_at_start = error_count;
   test_count++;
endtask

task automatic end_test();
   if (error_count == errors_at_start)
      $display("test %s: passed", cur_test);
   else
   begin
      failed_tests++;
      $display("test %s: failed with %0d errors", cur_test, error_count - errors_at_start);
   end
endtask

task automatic check_value(input string label, input logic [63:0] expected,
                           input logic [63:0] actual);
   check_count++;
   assert (actual === expected)
   else
   begin
      error_count++;
      $display("FAILED %s / %s: expected %0h, actual %0h", cur_test, label, expected, actual);
   end
endtask

task automatic report_failure(input string what);
   error_count++;
   $display("%s: %s", cur_test, what);
endtask

// header beat then address/data beat, like the core's rx stream
task automatic send_tlp(input logic [6:0] fmt_type, input logic [9:0] length,
                        input logic [31:0] byte_addr, input logic [31:0] data,
                        input logic [7:0] tag);
   req_hdr_t hdr;
   hdr              = '0;
   hdr.fmt_type     = fmt_type;
   hdr.length       = length;
   hdr.requester_id = host_id;
   hdr.tag          = tag;
   hdr.first_be     = 4'hf;
   @(posedge clock);
   #1;
   rx_tvalid = 1'b1;
   rx_tlast  = 1'b0;
   rx_tdata  = hdr;
   @(posedge clock);
   #1;
   rx_tlast = 1'b1;
   rx_tdata = {data, byte_addr};
   @(posedge clock);
   #1;
   rx_tvalid = 1'b0;
   rx_tlast  = 1'b0;
   rx_tdata  = '0;
endtask

task automatic mem_write(input logic [31:0] byte_addr, input logic [31:0] data);
   send_tlp(fmt_type_mwr32, 10'd1, byte_addr, data, 8'h00);
   // dword 0 is the FIFO data port, 16 words deep
   if (byte_addr[11:2] == 10'd0 && expected_words.size() < 16)
      expected_words.push_back(data);
endtask

task automatic collect_cpl(input bit stall);
   int   cycles;
   int   beats;
   logic got_last;
   cycles      = 0;
   beats       = 0;
   got_last    = 1'b0;
   first_valid = -1;
   cpl_qw0     = '0;
   cpl_qw1     = '0;
   while (!got_last && cycles < cpl_timeout)
   begin
      @(negedge clock);
      if (tx_tvalid && first_valid < 0)
         first_valid = cycles + 1;
      if (tx_tvalid && tx_tready)
      begin
         if (beats == 0)
            cpl_qw0 = tx_tdata;
         else
            cpl_qw1 = tx_tdata;
         beats++;
         got_last = tx_tlast;
      end
      @(posedge clock);
      #1;
      tx_tready = stall ? (({$random(seed)} % 3) != 0) : 1'b1;
      cycles++;
   end
   if (!got_last)
      report_failure("timed out waiting for the completion tlast beat");
   check_value("beats per completion", 2, beats);
   tx_tready = 1'b1;
endtask

task automatic check_cpl(input logic [7:0] tag, input logic [31:0] byte_addr,
                         input logic [31:0] exp_data);
   cpl_hdr_t hdr;
   hdr = cpl_qw0;
   // CplD of one dword, successful, four bytes
   check_value("cpl fmt_type", 64'h4a, hdr.fmt_type);
   check_value("cpl length", 1, hdr.length);
   check_value("cpl completer id", pci_id, hdr.completer_id);
   check_value("cpl status", 0, hdr.status);
   check_value("cpl byte count", 4, hdr.byte_count);
   check_value("cpl requester id", host_id, cpl_qw1[31:16]);
   check_value("cpl tag", tag, cpl_qw1[15:8]);
   check_value("cpl lower address", byte_addr[6:0], cpl_qw1[6:0]);
   check_value("cpl data", exp_data, cpl_qw1[63:32]);
endtask

task automatic read_reg(input logic [31:0] byte_addr, input logic [7:0] tag,
                        input bit stall, input logic [31:0] exp_data);
   send_tlp(fmt_type_mrd32, 10'd1, byte_addr, 32'h0, tag);
   collect_cpl(stall);
   check_cpl(tag, byte_addr, exp_data);
endtask

task automatic pop_word();
   int          wait_cnt;
   logic [31:0] exp;
   wait_cnt = 0;
   @(negedge clock);
   while (fifo_empty && wait_cnt < fifo_timeout)
   begin
      @(negedge clock);
      wait_cnt++;
   end
   if (fifo_empty)
      report_failure("timed out waiting for FIFO data");
   else if (expected_words.size() == 0)
      report_failure("FIFO holds a word that was never written");
   else
   begin
      exp = expected_words.pop_front();
      check_value("fifo_dout order", exp, fifo_dout);
   end
   @(posedge clock);
   #1;
   fifo_rd = 1'b1;
   @(posedge clock);
   #1;
   fifo_rd = 1'b0;
endtask

task automatic wait_tx_valid();
   int wait_cnt;
   wait_cnt = 0;
   @(negedge clock);
   while (!tx_tvalid && wait_cnt < cpl_timeout)
   begin
      @(negedge clock);
      wait_cnt++;
   end
   if (!tx_tvalid)
      report_failure("timed out waiting for tx_tvalid");
endtask

task automatic wait_interrupt(output int cycles);
   cycles = 0;
   @(negedge clock);
   while (!interrupt && cycles < irq_timeout)
   begin
      @(negedge clock);
      cycles++;
   end
   if (!interrupt)
      report_failure("timed out waiting for interrupt");
endtask

// one-cycle interrupt_rdy pulse, as the core gives when it takes the MSI
task automatic clear_interrupt();
   @(posedge clock);
   #1;
   interrupt_rdy = 1'b1;
   @(posedge clock);
   #1;
   interrupt_rdy = 1'b0;
   @(negedge clock);
   check_value("interrupt after interrupt_rdy", 0, interrupt);
endtask

// File: tb/hififo_tb.sv
// testbench for hififo_top that plays the PCIe core on both streams and checks link, FIFO, reads and MSI
`timescale 1ns/10ps

module hififo_tb;
   import hififo_pkg::*;

   localparam int clk_half       = 20;
   localparam int cpl_timeout    = 60;
   localparam int fifo_timeout   = 20;
   localparam int irq_timeout    = 120;
   localparam int holdoff_cycles = 64;
   // requester id of the emulated root complex
   localparam logic [15:0] host_id = 16'h0100;

   logic        clock;
   logic        rst;
   logic        user_reset;
   logic        user_lnk_up;
   logic        cfg_to_turnoff;
   logic        cfg_turnoff_ok;
   logic        pci_reset;
   pci_id_t     pci_id;
   logic        rx_tvalid;
   logic        rx_tlast;
   logic [63:0] rx_tdata;
   logic        tx_tvalid;
   logic        tx_tready;
   logic        tx_tlast;
   logic [63:0] tx_tdata;
   logic        interrupt;
   logic        interrupt_rdy;
   logic [3:0]  interrupt_num;
   logic        fifo_rd;
   logic [31:0] fifo_dout;
   logic        fifo_empty;

   integer      seed = 32'hf33c_8d49;
   int          error_count;
   int          check_count;
   int          test_count;
   int          failed_tests;
   int          errors_at_start;
   string       cur_test;
   logic [31:0] expected_words[$];
   logic [63:0] cpl_qw0;
   logic [63:0] cpl_qw1;
   int          first_valid;
   int          waited;
   int          i;

   hififo_top i_hififo_top (
      .clock          (clock),
      .rst            (rst),
      .user_reset     (user_reset),
      .user_lnk_up    (user_lnk_up),
      .cfg_to_turnoff (cfg_to_turnoff),
      .cfg_turnoff_ok (cfg_turnoff_ok),
      .pci_reset      (pci_reset),
      .pci_id         (pci_id),
      .rx_tvalid      (rx_tvalid),
      .rx_tlast       (rx_tlast),
      .rx_tdata       (rx_tdata),
      .tx_tvalid      (tx_tvalid),
      .tx_tready      (tx_tready),
      .tx_tlast       (tx_tlast),
      .tx_tdata       (tx_tdata),
      .interrupt      (interrupt),
      .interrupt_rdy  (interrupt_rdy),
      .interrupt_num  (interrupt_num),
      .fifo_rd        (fifo_rd),
      .fifo_dout      (fifo_dout),
      .fifo_empty     (fifo_empty)
   );

   always #clk_half clock = ~clock;

   // a stalled beat keeps its data and tlast
   tx_hold: assert property (@(posedge clock) disable iff (rst || pci_reset)
      (tx_tvalid && !tx_tready) |=> (tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast)))
   else
   begin
      error_count = error_count + 1;
      $display("%s: transmit beat changed while stalled by tx_tready", cur_test);
   end

   // MSI request drops once the core takes it
   irq_release: assert property (@(posedge clock) disable iff (rst || pci_reset)
      (interrupt && interrupt_rdy) |=> !interrupt)
   else
   begin
      error_count = error_count + 1;
      $display("%s: interrupt stayed high after interrupt_rdy", cur_test);
   end

   // no turn-off ack with a completion still on the wire
   turnoff_idle: assert property (@(posedge clock) disable iff (rst || pci_reset)
      $rose(cfg_turnoff_ok) |-> !tx_tvalid)
   else
   begin
      error_count = error_count + 1;
      $display("%s: cfg_turnoff_ok rose while a completion was pending", cur_test);
   end

   `include "hififo_tb_tasks.svh"

   initial
   begin
      clock          = 1'b0;
      rst            = 1'b1;
      user_reset     = 1'b0;
      user_lnk_up    = 1'b0;
      cfg_to_turnoff = 1'b0;
      pci_id         = '{bus: 8'h0a, dev: 5'd3, func: 3'd0};
      rx_tvalid      = 1'b0;
      rx_tlast       = 1'b0;
      rx_tdata       = '0;
      tx_tready      = 1'b1;
      interrupt_rdy  = 1'b0;
      fifo_rd        = 1'b0;
      error_count    = 0;
      check_count    = 0;
      test_count     = 0;
      failed_tests   = 0;
      cur_test       = "reset";
      repeat (8) @(posedge clock);
      #1;
      rst = 1'b0;

      start_test("link_up");
      @(negedge clock);
      check_value("pci_reset after rst", 1, pci_reset);
      check_value("tx_tvalid after rst", 0, tx_tvalid);
      check_value("interrupt after rst", 0, interrupt);
      check_value("cfg_turnoff_ok after rst", 0, cfg_turnoff_ok);
      repeat (3) @(negedge clock);
      check_value("pci_reset while link down", 1, pci_reset);
      @(posedge clock);
      #1;
      user_lnk_up = 1'b1;
      @(negedge clock);
      check_value("pci_reset in link-up cycle", 1, pci_reset);
      @(negedge clock);
      check_value("pci_reset one cycle after link-up", 0, pci_reset);
      end_test();

      start_test("fifo_path");
      for (i = 0; i < 5; i++)
      begin
         if (i == 3)
         begin
            // neither the fifth dword nor a two-dword write reaches the FIFO
            send_tlp(fmt_type_mwr32, 10'd1, 32'h10, 32'hdead_0004, 8'h00);
            send_tlp(fmt_type_mwr32, 10'd2, 32'h0, 32'hdead_0002, 8'h00);
         end
         mem_write(32'h0, $random(seed));
      end
      for (i = 0; i < 5; i++)
         pop_word();
      @(negedge clock);
      check_value("fifo_empty after all pops", 1, fifo_empty);
      end_test();

      start_test("status_read");
      for (i = 0; i < 4; i++)
         mem_write(32'h0, $random(seed));
      pop_word();
      read_reg(32'h4, 8'h5c, 1'b0, expected_words.size());
      // tlast beat, rd_strobe cycle, then the header beat
      check_value("first beat latency", 2, first_valid);
      read_reg(32'h8, 8'h5d, 1'b0, 32'd16);
      end_test();

      start_test("back_pressure");
      for (i = 0; i < 6; i++)
      begin
         if (i % 2 == 0)
            read_reg(32'h4, 8'h60 + 8'(i), 1'b1, expected_words.size());
         else
            read_reg(32'h8, 8'h60 + 8'(i), 1'b1, 32'd16);
         repeat (3)
         begin
            @(negedge clock);
            check_value("no beat after tlast", 0, tx_tvalid);
         end
      end
      end_test();

      start_test("turnoff");
      @(posedge clock);
      #1;
      tx_tready = 1'b0;
      send_tlp(fmt_type_mrd32, 10'd1, 32'h4, 32'h0, 8'h71);
      wait_tx_valid();
      @(posedge clock);
      #1;
      cfg_to_turnoff = 1'b1;
      repeat (6)
      begin
         @(negedge clock);
         check_value("cfg_turnoff_ok while completion pending", 0, cfg_turnoff_ok);
      end
      collect_cpl(1'b0);
      check_cpl(8'h71, 32'h4, expected_words.size());
      @(negedge clock);
      check_value("cfg_turnoff_ok after last beat", 1, cfg_turnoff_ok);
      repeat (3)
      begin
         @(negedge clock);
         check_value("cfg_turnoff_ok held", 1, cfg_turnoff_ok);
      end
      @(posedge clock);
      #1;
      cfg_to_turnoff = 1'b0;
      repeat (2) @(negedge clock);
      check_value("cfg_turnoff_ok after request drops", 0, cfg_turnoff_ok);
      end_test();

      start_test("interrupts");
      for (i = expected_words.size(); i > 0; i--)
         pop_word();
      clear_interrupt();
      mem_write(32'h8, 32'd3);
      mem_write(32'h0, $random(seed));
      mem_write(32'h0, $random(seed));
      // long enough for a fire on the second push to show
      repeat (3) @(negedge clock);
      check_value("interrupt below threshold", 0, interrupt);
      mem_write(32'h0, $random(seed));
      wait_interrupt(waited);
      check_value("threshold interrupt latency", 2, waited);
      check_value("threshold vector", 0, interrupt_num);
      clear_interrupt();
      for (i = 0; i < 3; i++)
         pop_word();
      // a single word so only the holdoff timer can fire
      mem_write(32'h0, $random(seed));
      wait_interrupt(waited);
      check_value("holdoff wait reached", 1, waited >= holdoff_cycles);
      check_value("timeout vector", 1, interrupt_num);
      clear_interrupt();
      pop_word();
      end_test();

      $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// File: hififo.f
+incdir+tb
rtl/hififo_pkg.sv
rtl/pcie_link_ctrl.sv
rtl/tlp_rx_decoder.sv
rtl/h2c_fifo.sv
rtl/irq_holdoff_timer.sv
rtl/cpl_tx_builder.sv
rtl/hififo_top.sv
tb/hififo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the hififo testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module hififo_tb \
   -f hififo.f -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vhififo_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
   echo "no result line in $LOG"
   exit 1
fi
exit 0
